// File: flist.f
+incdir+hw
hw/sparse_data_pkg.sv
hw/sparse_ctrl_pkg.sv
hw/scan_if.sv
hw/operand_buffer.sv
hw/match_scanner.sv
hw/sparse_mac.sv
hw/sparse_dot_top.sv
verification/sparse_dot_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= sparse_dot_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Verification passed

SOURCES := $(wildcard hw/*.sv hw/*.svh verification/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the available targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/sparse_dot_tb.sv
`include "sparse_cfg.svh"

module sparse_dot_tb import sparse_data_pkg::*, sparse_ctrl_pkg::*; ();

	localparam int RUN_TIMEOUT = 64;

	logic      clk_i;
	logic      rst_i;
	logic      ifm_we_i;
	vec_addr_t ifm_addr_i;
	ifm_t      ifm_data_i;
	logic      wgt_we_i;
	vec_addr_t wgt_addr_i;
	wgt_t      wgt_data_i;
	logic      start_i;
	logic      busy_o;
	logic      match_valid_o;
	vec_addr_t match_addr_o;
	logic      done_o;
	acc_t      result_o;

	// Shadow copies of everything written
	ifm_t       ifm_sh [`SPARSE_VEC_LEN];
	wgt_t       wgt_sh [`SPARSE_VEC_LEN];

	// Expected outcome of the current run
	mask_t      exp_mask;
	acc_t       exp_sum;
	match_cnt_t exp_cnt;

	// Strobes seen so far in the current run
	match_cnt_t seen_cnt;
	vec_addr_t  prev_addr;
	logic       have_prev;

	int seed;
	int mismatch_cnt;
	int other_cnt;

	sparse_dot_top sparse_dot_top_inst (
		 .clk_i         (clk_i)
		,.rst_i         (rst_i)
		,.ifm_we_i      (ifm_we_i)
		,.ifm_addr_i    (ifm_addr_i)
		,.ifm_data_i    (ifm_data_i)
		,.wgt_we_i      (wgt_we_i)
		,.wgt_addr_i    (wgt_addr_i)
		,.wgt_data_i    (wgt_data_i)
		,.start_i       (start_i)
		,.busy_o        (busy_o)
		,.match_valid_o (match_valid_o)
		,.match_addr_o  (match_addr_o)
		,.done_o        (done_o)
		,.result_o      (result_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		if (rst_i || done_o) begin
			seen_cnt  <= '0;
			have_prev <= 1'b0;
		end
		else if (match_valid_o) begin
			seen_cnt  <= seen_cnt + match_cnt_t'(1);
			prev_addr <= match_addr_o;
			have_prev <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	result_chk: assert property (@(posedge clk_i) disable iff (rst_i)
		done_o |-> result_o == exp_sum)
	else begin
		mismatch_cnt++;
		$display("MISMATCH time=%0t signal=result_o expected=%0d actual=%0d",
			$time, $sampled(exp_sum), $sampled(result_o));
	end

	match_pos_chk: assert property (@(posedge clk_i) disable iff (rst_i)
		match_valid_o |-> exp_mask[match_addr_o])
	else begin
		mismatch_cnt++;
		$display("MISMATCH time=%0t signal=match_addr_o expected=bit of mask %h actual=%0d",
			$time, $sampled(exp_mask), $sampled(match_addr_o));
	end

	// Addresses climb within a run
	order_chk: assert property (@(posedge clk_i) disable iff (rst_i)
		match_valid_o && have_prev |-> match_addr_o > prev_addr)
	else begin
		mismatch_cnt++;
		$display("MISMATCH time=%0t signal=match_addr_o expected=above %0d actual=%0d",
			$time, $sampled(prev_addr), $sampled(match_addr_o));
	end

	count_chk: assert property (@(posedge clk_i) disable iff (rst_i)
		done_o |-> seen_cnt == exp_cnt)
	else begin
		mismatch_cnt++;
		$display("MISMATCH time=%0t signal=match_valid_o count expected=%0d actual=%0d",
			$time, $sampled(exp_cnt), $sampled(seen_cnt));
	end

	extra_chk: assert property (@(posedge clk_i) disable iff (rst_i)
		match_valid_o |-> seen_cnt < exp_cnt)
	else begin
		other_cnt++;
		$display("Match strobe beyond the expected count at time %0t", $time);
	end

	done_follow_chk: assert property (@(posedge clk_i) disable iff (rst_i)
		match_valid_o && (seen_cnt + match_cnt_t'(1) == exp_cnt) |=> done_o)
	else begin
		other_cnt++;
		$display("done_o missing in the cycle after the final match, time %0t", $time);
	end

	done_pulse_chk: assert property (@(posedge clk_i) disable iff (rst_i)
		done_o |=> !done_o)
	else begin
		other_cnt++;
		$display("done_o held high for more than one cycle at time %0t", $time);
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model and stimulus
	//////////////////////////////////////////////////////////////////////

	function automatic void update_expect();
		int sum;
		sum      = 0;
		exp_mask = '0;
		exp_cnt  = '0;
		for (int i = 0; i < `SPARSE_VEC_LEN; i++) begin
			if (ifm_sh[i] != '0 && wgt_sh[i] != '0) begin
				exp_mask[i] = 1'b1;
				exp_cnt     = exp_cnt + match_cnt_t'(1);
				sum        += int'(ifm_sh[i]) * int'(wgt_sh[i]);
			end
		end
		exp_sum = acc_t'(sum);
	endfunction

	// Entered at a falling edge, leaves at the next one
	task automatic write_pair(input int pos, input ifm_t f, input wgt_t w);
		ifm_we_i    = 1'b1;
		ifm_addr_i  = vec_addr_t'(pos);
		ifm_data_i  = f;
		wgt_we_i    = 1'b1;
		wgt_addr_i  = vec_addr_t'(pos);
		wgt_data_i  = w;
		ifm_sh[pos] = f;
		wgt_sh[pos] = w;
		@(negedge clk_i);
	endtask

	task automatic end_writes();
		ifm_we_i = 1'b0;
		wgt_we_i = 1'b0;
		@(negedge clk_i);
	endtask

	task automatic fill_random(input bit dense);
		ifm_t f;
		wgt_t w;
		for (int i = 0; i < `SPARSE_VEC_LEN; i++) begin
			f = ifm_t'($random(seed));
			w = wgt_t'($random(seed));
			if (dense) begin
				f[0] = 1'b1;
				w[0] = 1'b1;
			end
			else begin
				if (($random(seed) & 32'd1) == 32'd0) begin
					f = '0;
				end
				if (($random(seed) & 32'd1) == 32'd0) begin
					w = '0;
				end
			end
			write_pair(i, f, w);
		end
		end_writes();
	endtask

	// One run; extra_start repeats the pulse while the run is busy
	task automatic run_dot(input bit extra_start);
		int cycles;
		update_expect();
		start_i = 1'b1;
		@(negedge clk_i);
		start_i = extra_start;
		assert (busy_o === 1'b1)
		else begin
			mismatch_cnt++;
			$display("MISMATCH time=%0t signal=busy_o expected=1 actual=%b", $time, busy_o);
		end
		@(negedge clk_i);
		start_i = 1'b0;
		cycles  = 0;
		while (!done_o && cycles < RUN_TIMEOUT) begin
			@(negedge clk_i);
			cycles++;
		end
		assert (done_o)
		else begin
			other_cnt++;
			$display("Timeout, done_o not seen within %0d cycles at time %0t",
				RUN_TIMEOUT, $time);
		end
		@(negedge clk_i);
	endtask

	initial begin
		seed         = 32'hb42e;
		mismatch_cnt = 0;
		other_cnt    = 0;
		rst_i        = 1'b1;
		ifm_we_i     = 1'b0;
		ifm_addr_i   = '0;
		ifm_data_i   = '0;
		wgt_we_i     = 1'b0;
		wgt_addr_i   = '0;
		wgt_data_i   = '0;
		start_i      = 1'b0;
		exp_mask     = '0;
		exp_sum      = '0;
		exp_cnt      = '0;
		for (int i = 0; i < `SPARSE_VEC_LEN; i++) begin
			ifm_sh[i] = '0;
			wgt_sh[i] = '0;
		end

		repeat (3) @(negedge clk_i);
		rst_i = 1'b0;
		assert (busy_o === 1'b0)
		else begin
			mismatch_cnt++;
			$display("MISMATCH time=%0t signal=busy_o expected=0 actual=%b", $time, busy_o);
		end
		assert (done_o === 1'b0)
		else begin
			mismatch_cnt++;
			$display("MISMATCH time=%0t signal=done_o expected=0 actual=%b", $time, done_o);
		end

		// Buffers hold only zeros after reset
		run_dot(1'b0);

		for (int r = 0; r < 6; r++) begin
			fill_random(1'b0);
			run_dot(r[0]);
		end

		// No shared nonzero position
		for (int i = 0; i < `SPARSE_VEC_LEN; i++) begin
			if (i % 2 == 0) begin
				write_pair(i, ifm_t'(i + 1), '0);
			end
			else begin
				write_pair(i, '0, wgt_t'(-i));
			end
		end
		end_writes();
		run_dot(1'b1);

		// Every position matches
		fill_random(1'b1);
		run_dot(1'b1);

		// Zero writes pull positions out of the next run
		write_pair(5, '0, wgt_sh[5]);
		write_pair(9, ifm_sh[9], '0);
		end_writes();
		run_dot(1'b0);

		$display("Errors: mismatches=%0d other=%0d", mismatch_cnt, other_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0) begin
			$display("Verification passed");
		end
		else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: hw/sparse_dot_top.sv
module sparse_dot_top import sparse_data_pkg::*; (
	 input  logic      clk_i
	,input  logic      rst_i

	// Feature map write port
	,input  logic      ifm_we_i
	,input  vec_addr_t ifm_addr_i
	,input  ifm_t      ifm_data_i

	// Weight write port
	,input  logic      wgt_we_i
	,input  vec_addr_t wgt_addr_i
	,input  wgt_t      wgt_data_i

	,input  logic      start_i

	// Status and results
	,output logic      busy_o
	,output logic      match_valid_o
	,output vec_addr_t match_addr_o
	,output logic      done_o
	,output acc_t      result_o
);

	mask_t     ifm_mask_w;
	mask_t     wgt_mask_w;
	vec_addr_t rd_addr_w;
	ifm_t      ifm_rd_w;
	wgt_t      wgt_rd_w;

	scan_if scan_if_inst ();

	//////////////////////////////////////////////////////////////////////
	// Operand buffers
	//////////////////////////////////////////////////////////////////////

	operand_buffer #(
		.payload_t (ifm_t)
	) ifm_buf_inst (
		 .clk_i     (clk_i)
		,.rst_i     (rst_i)
		,.we_i      (ifm_we_i)
		,.wr_addr_i (ifm_addr_i)
		,.wr_data_i (ifm_data_i)
		,.rd_addr_i (rd_addr_w)
		,.rd_data_o (ifm_rd_w)
		,.mask_o    (ifm_mask_w)
	);

	operand_buffer #(
		.payload_t (wgt_t)
	) wgt_buf_inst (
		 .clk_i     (clk_i)
		,.rst_i     (rst_i)
		,.we_i      (wgt_we_i)
		,.wr_addr_i (wgt_addr_i)
		,.wr_data_i (wgt_data_i)
		,.rd_addr_i (rd_addr_w)
		,.rd_data_o (wgt_rd_w)
		,.mask_o    (wgt_mask_w)
	);

	//////////////////////////////////////////////////////////////////////
	// Scanner and MAC
	//////////////////////////////////////////////////////////////////////

	match_scanner match_scanner_inst (
		 .clk_i      (clk_i)
		,.rst_i      (rst_i)
		,.start_i    (start_i)
		,.ifm_mask_i (ifm_mask_w)
		,.wgt_mask_i (wgt_mask_w)
		,.busy_o     (busy_o)
		,.scan       (scan_if_inst.scanner)
	);

	sparse_mac sparse_mac_inst (
		 .clk_i     (clk_i)
		,.rst_i     (rst_i)
		,.scan      (scan_if_inst.consumer)
		,.rd_addr_o (rd_addr_w)
		,.ifm_i     (ifm_rd_w)
		,.wgt_i     (wgt_rd_w)
		,.done_o    (done_o)
		,.result_o  (result_o)
	);

	assign match_valid_o = scan_if_inst.valid;
	assign match_addr_o  = scan_if_inst.addr;

endmodule

// File: hw/sparse_mac.sv
module sparse_mac import sparse_data_pkg::*; (
	 input  logic      clk_i
	,input  logic      rst_i
	,scan_if.consumer  scan

	// Shared read address into both buffers
	,output vec_addr_t rd_addr_o
	,input  ifm_t      ifm_i
	,input  wgt_t      wgt_i

	,output logic      done_o
	,output acc_t      result_o
);

	acc_t acc_q;
	logic done_q;
	acc_t ifm_ext_w;
	acc_t wgt_ext_w;
	acc_t prod_w;

	// Buffers answer in the same cycle
	assign rd_addr_o = scan.addr;

	//////////////////////////////////////////////////////////////////////
	// Multiply
	//////////////////////////////////////////////////////////////////////

	// Feature value is zero-extended before the signed product
	assign ifm_ext_w = acc_t'($signed({1'b0, ifm_i}));
	assign wgt_ext_w = acc_t'(wgt_i);
	assign prod_w    = ifm_ext_w * wgt_ext_w;

	//////////////////////////////////////////////////////////////////////
	// Accumulate
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			acc_q  <= '0;
			done_q <= 1'b0;
		end
		else begin
			done_q <= scan.last || scan.empty;
			if (scan.clear) begin
				acc_q <= '0;
			end
			else if (scan.valid) begin
				acc_q <= acc_q + prod_w;
			end
		end
	end

	// Sum stays put until the next clear
	assign result_o = acc_q;
	assign done_o   = done_q;

endmodule

// File: hw/match_scanner.sv
`include "sparse_cfg.svh"

module match_scanner import sparse_data_pkg::*, sparse_ctrl_pkg::*; (
	 input  logic   clk_i
	,input  logic   rst_i
	,input  logic   start_i
	,input  mask_t  ifm_mask_i
	,input  mask_t  wgt_mask_i
	,output logic   busy_o
	,scan_if.scanner scan
);

	scan_state_e state_q;
	mask_t       remain_q;
	logic        empty_q;

	mask_t       isect_w;
	match_cnt_t  isect_cnt_w;
	logic        accept_w;
	vec_addr_t   pick_addr_w;
	mask_t       remain_next_w;

	function automatic match_cnt_t popcount(mask_t m);
		match_cnt_t cnt;
		cnt = '0;
		for (int i = 0; i < `SPARSE_VEC_LEN; i++) begin
			cnt = cnt + match_cnt_t'(m[i]);
		end
		return cnt;
	endfunction

	assign isect_w     = ifm_mask_i & wgt_mask_i;
	assign isect_cnt_w = popcount(isect_w);

	// Starts are dropped while a run is in flight
	assign accept_w = start_i && (state_q == SCAN_IDLE) && !empty_q;

	//////////////////////////////////////////////////////////////////////
	// Priority encoder, lowest set bit wins
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		pick_addr_w = '0;
		for (int i = `SPARSE_VEC_LEN - 1; i >= 0; i--) begin
			if (remain_q[i]) begin
				pick_addr_w = vec_addr_t'(i);
			end
		end
		remain_next_w = remain_q;
		remain_next_w[pick_addr_w] = 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Walk control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q  <= SCAN_IDLE;
			remain_q <= '0;
			empty_q  <= 1'b0;
		end
		else begin
			// Empty intersection is reported one cycle after the start
			empty_q <= accept_w && (isect_cnt_w == '0);
			case (state_q)
				SCAN_IDLE: begin
					if (accept_w) begin
						remain_q <= isect_w;
						if (isect_cnt_w != '0) begin
							state_q <= SCAN_WALK;
						end
					end
				end
				SCAN_WALK: begin
					remain_q <= remain_next_w;
					if (remain_next_w == '0) begin
						state_q <= SCAN_IDLE;
					end
				end
				default: state_q <= SCAN_IDLE;
			endcase
		end
	end

	assign scan.clear = accept_w;
	assign scan.valid = (state_q == SCAN_WALK);
	assign scan.addr  = pick_addr_w;
	assign scan.last  = (state_q == SCAN_WALK) && (remain_next_w == '0);
	assign scan.empty = empty_q;

	assign busy_o = (state_q == SCAN_WALK) || empty_q;

endmodule

// File: hw/operand_buffer.sv
`include "sparse_cfg.svh"

module operand_buffer import sparse_data_pkg::*; #(
	parameter type payload_t = logic [7:0]
) (
	 input  logic      clk_i
	,input  logic      rst_i

	// Write port
	,input  logic      we_i
	,input  vec_addr_t wr_addr_i
	,input  payload_t  wr_data_i

	// Read port, combinational
	,input  vec_addr_t rd_addr_i
	,output payload_t  rd_data_o

	,output mask_t     mask_o
);

	payload_t mem_q [`SPARSE_VEC_LEN];
	mask_t    mask_q;
	logic     wr_nonzero_w;

	assign wr_nonzero_w = (wr_data_i != '0);

	//////////////////////////////////////////////////////////////////////
	// Value storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < `SPARSE_VEC_LEN; i++) begin
				mem_q[i] <= '0;
			end
		end
		else if (we_i) begin
			mem_q[wr_addr_i] <= wr_data_i;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Nonzero mask
	//////////////////////////////////////////////////////////////////////

	// Writing a zero drops the position out of later scans
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mask_q <= '0;
		end
		else if (we_i) begin
			mask_q[wr_addr_i] <= wr_nonzero_w;
		end
	end

	assign rd_data_o = mem_q[rd_addr_i];
	assign mask_o    = mask_q;

endmodule

// File: hw/scan_if.sv
interface scan_if import sparse_data_pkg::*; ();

	logic      clear;
	logic      valid;
	vec_addr_t addr;
	logic      last;
	logic      empty;

	modport scanner (
		output clear,
		output valid,
		output addr,
		output last,
		output empty
	);

	modport consumer (
		input clear,
		input valid,
		input addr,
		input last,
		input empty
	);

endinterface

// File: hw/sparse_ctrl_pkg.sv
package sparse_ctrl_pkg;

	import sparse_data_pkg::*;

	typedef enum logic {
		SCAN_IDLE,
		SCAN_WALK
	} scan_state_e;

	// Matches per run, up to the full vector length
	typedef logic [$bits(vec_addr_t):0] match_cnt_t;

endpackage

// File: hw/sparse_data_pkg.sv
`include "sparse_cfg.svh"

package sparse_data_pkg;

	// Feature map values are unsigned activations
	typedef logic [`SPARSE_IFM_W-1:0] ifm_t;

	// Filter weights are two's complement
	typedef logic signed [`SPARSE_WGT_W-1:0] wgt_t;

	// Position index within a vector
	typedef logic [$clog2(`SPARSE_VEC_LEN)-1:0] vec_addr_t;

	// One bit per position, set when the stored value is nonzero
	typedef logic [`SPARSE_VEC_LEN-1:0] mask_t;

	typedef logic signed [`SPARSE_ACC_W-1:0] acc_t;

endpackage

// File: hw/sparse_cfg.svh
`ifndef SPARSE_CFG_SVH
`define SPARSE_CFG_SVH

// Vector geometry
`define SPARSE_VEC_LEN 16

// Operand widths
`define SPARSE_IFM_W 8
`define SPARSE_WGT_W 8

// 16 products of u8 x s8 plus sign
`define SPARSE_ACC_W 22

`endif
